// ==== all.f ====
common/uart_pkg.sv
rtl/baud_tick_gen.sv
uart_receiver/uart_receiver.sv
uart_transmitter/uart_transmitter.sv
rtl/uart_axil_regs.sv
rtl/uart_top.sv
dv/tb_clock_gen.sv
dv/uart_sva.sv
dv/uart_tb.sv

// ==== common/uart_pkg.sv ====
`default_nettype none

package uart_pkg;

	// ************************************************************************
	// Widths and reset values
	// ************************************************************************
	localparam int DATA_W     = 8;
	localparam int AXI_ADDR_W = 4;
	localparam int AXI_DATA_W = 32;
	localparam int DIV_W      = 16;
	localparam int BIT_CNT_W  = $clog2(DATA_W) + 1;

	localparam logic [DIV_W-1:0] DIV_RESET = 16;
	localparam logic [DIV_W-1:0] DIV_MIN   = 2;    // Shortest usable bit period

	// Register map, one word each
	typedef enum logic [AXI_ADDR_W-1:0] {
		ADDR_TXDATA = 4'h0,
		ADDR_RXDATA = 4'h4,
		ADDR_STATUS = 4'h8,
		ADDR_CTRL   = 4'hC
	} reg_addr_e;

	// STATUS bits
	localparam int ST_TX_BUSY   = 0;
	localparam int ST_RX_VALID  = 1;
	localparam int ST_FRAME_ERR = 2;    // Sticky, write 1 to clear
	localparam int ST_OVERRUN   = 3;    // Sticky, write 1 to clear

	// CTRL fields
	localparam int CTRL_DIV_LSB  = 0;
	localparam int CTRL_LOOPBACK = 16;

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_DATA,
		RX_STOP
	} rx_state_e;

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_e;

	// One received frame
	typedef struct packed {
		logic              valid;
		logic              framing_error;
		logic [DATA_W-1:0] data;
	} rx_result_t;

	// Send request to the transmitter
	typedef struct packed {
		logic              valid;
		logic [DATA_W-1:0] data;
	} tx_req_t;

endpackage

`default_nettype wire

// ==== dv/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic o_CLK,
	output logic o_RESET
);

	localparam int HALF_PERIOD  = 20;    // 40 ns clock
	localparam int RESET_CYCLES = 5;

	initial
	begin
		o_CLK = 1'b0;
		forever #(HALF_PERIOD) o_CLK = ~o_CLK;
	end

	initial
	begin
		o_RESET = 1'b1;
		repeat (RESET_CYCLES) @(posedge o_CLK);
		@(negedge o_CLK);
		o_RESET = 1'b0;
	end

endmodule

`default_nettype wire

// ==== dv/uart_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_sva (
	input wire                       i_CLK,
	input wire                       i_RESET,
	input wire                       i_bvalid,
	input wire                       i_bready,
	input wire                       i_rvalid,
	input wire                       i_rready,
	input wire uart_pkg::rx_result_t i_result,
	input wire                       i_loopback,
	input wire                       i_tx
);

	// Responses held until the host takes them
	b_hold: assert property (@(posedge i_CLK) disable iff (i_RESET)
		i_bvalid && !i_bready |=> i_bvalid)
		else $error("write response dropped before bready");
	r_hold: assert property (@(posedge i_CLK) disable iff (i_RESET)
		i_rvalid && !i_rready |=> i_rvalid)
		else $error("read response dropped before rready");

	rx_pulse: assert property (@(posedge i_CLK) disable iff (i_RESET)
		i_result.valid |=> !i_result.valid)
		else $error("receiver result valid for more than one cycle");
	fe_zero: assert property (@(posedge i_CLK) disable iff (i_RESET)
		i_result.valid && i_result.framing_error |-> i_result.data == '0)
		else $error("framing error frame carries nonzero data");

	lb_idle: assert property (@(posedge i_CLK) disable iff (i_RESET)
		i_loopback |-> i_tx)    // Pin parked while looped back
		else $error("TX pin left idle state during loopback");

endmodule

bind uart_top uart_sva u_sva (
	.i_CLK      (i_CLK),
	.i_RESET    (i_RESET),
	.i_bvalid   (o_bvalid),
	.i_bready   (i_bready),
	.i_rvalid   (o_rvalid),
	.i_rready   (i_rready),
	.i_result   (rx_result),
	.i_loopback (loopback),
	.i_tx       (o_TX)
);

`default_nettype wire

// ==== dv/uart_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_tb;

	localparam int MIN_DIV     = 4;
	localparam int MAX_DIV     = 12;
	localparam int N_RAND      = 3;    // Frames per random test
	localparam int N_FRAMES    = 3 * N_RAND + 8;
	localparam int CYCLE_LIMIT = N_FRAMES * 10 * MAX_DIV * 2 + 2000;    // Room for polling and gaps

	logic                            clk;
	logic                            rst;
	logic                            awvalid;
	logic                            wvalid;
	logic                            bready;
	logic                            arvalid;
	logic                            rready;
	logic                            rx;
	logic [uart_pkg::AXI_ADDR_W-1:0] awaddr;
	logic [uart_pkg::AXI_ADDR_W-1:0] araddr;
	logic [uart_pkg::AXI_DATA_W-1:0] wdata;
	wire                             awready;
	wire                             wready;
	wire                             bvalid;
	wire                             arready;
	wire                             rvalid;
	wire                             tx;
	wire  [1:0]                      bresp;
	wire  [1:0]                      rresp;
	wire  [uart_pkg::AXI_DATA_W-1:0] rdata;

	logic [31:0] rng;
	int          cycles = 0;
	int          fail_count = 0;
	int          div;
	logic        lb_watch;
	// Handshakes on the AW, W and AR channels
	int          aw_hs = 0;
	int          w_hs = 0;
	int          ar_hs = 0;
	// Expected register contents
	logic [7:0]  m_rx_data;
	logic        m_rx_valid;
	logic        m_frame_err;
	logic        m_overrun;

	tb_clock_gen u_clk (.o_CLK(clk), .o_RESET(rst));

	uart_top u_dut (
		.i_CLK(clk), .i_RESET(rst),
		.i_awvalid(awvalid), .o_awready(awready), .i_awaddr(awaddr),
		.i_wvalid(wvalid), .o_wready(wready), .i_wdata(wdata),
		.o_bvalid(bvalid), .i_bready(bready), .o_bresp(bresp),
		.i_arvalid(arvalid), .o_arready(arready), .i_araddr(araddr),
		.o_rvalid(rvalid), .i_rready(rready), .o_rdata(rdata), .o_rresp(rresp),
		.i_RX(rx), .o_TX(tx)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	function automatic int rand_range(input int lo, input int hi);
		rng = xorshift32(rng);
		return lo + int'(rng % 32'(hi - lo + 1));
	endfunction

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act)
		begin
			fail_count++;
			$display("error %s expected %0h actual %0h", name, exp, act);
			$display("RESULT: FAIL");
			$fatal(1, "mismatch in %s", name);
		end
	endtask

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles > CYCLE_LIMIT)
		begin
			$display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
			$display("RESULT: FAIL");
			$fatal(1, "timeout");
		end
	end

	always @(posedge clk)
	begin
		if (awvalid && awready)
			aw_hs <= aw_hs + 1;
		if (wvalid && wready)
			w_hs <= w_hs + 1;
		if (arvalid && arready)
			ar_hs <= ar_hs + 1;
	end

	always @(negedge clk)
		if (lb_watch)
			check("loopback tx idle", 32'd1, 32'(tx));

	function automatic logic [31:0] exp_status(input logic busy);
		logic [31:0] w;
		w = '0;
		w[uart_pkg::ST_TX_BUSY]   = busy;
		w[uart_pkg::ST_RX_VALID]  = m_rx_valid;
		w[uart_pkg::ST_FRAME_ERR] = m_frame_err;
		w[uart_pkg::ST_OVERRUN]   = m_overrun;
		return w;
	endfunction

	// ************************************************************************
	// AXI4-Lite host, one access at a time
	// ************************************************************************
	task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
		output logic [1:0] resp);
		int aw_start;
		int w_start;
		aw_start = aw_hs;
		w_start  = w_hs;
		@(negedge clk);
		awvalid = 1'b1;
		wvalid  = 1'b1;
		awaddr  = addr;
		wdata   = data;
		do
			@(negedge clk);
		while (aw_hs == aw_start);
		awvalid = 1'b0;
		wvalid  = 1'b0;
		check("w handshake with aw", 32'(w_start + 1), 32'(w_hs));
		check("bvalid after write", 32'd1, 32'(bvalid));    // Response one cycle later
		resp = bresp;
	endtask

	task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		int ar_start;
		ar_start = ar_hs;
		@(negedge clk);
		arvalid = 1'b1;
		araddr  = addr;
		do
			@(negedge clk);
		while (ar_hs == ar_start);
		arvalid = 1'b0;
		check("rvalid after read", 32'd1, 32'(rvalid));
		data    = rdata;
		resp    = rresp;
	endtask

	task automatic write_check(input string name, input logic [3:0] addr,
		input logic [31:0] data, input logic [1:0] exp_resp);
		logic [1:0] resp;
		axi_write(addr, data, resp);
		check(name, 32'(exp_resp), 32'(resp));
	endtask

	task automatic read_check(input string name, input logic [3:0] addr, input logic [31:0] exp);
		logic [31:0] data;
		logic [1:0]  resp;
		axi_read(addr, data, resp);
		check({name, " resp"}, 32'(uart_pkg::RESP_OKAY), 32'(resp));
		check(name, exp, data);
	endtask

	task automatic wait_status(input int idx, input logic val);
		logic [31:0] data;
		logic [1:0]  resp;
		do
			axi_read(uart_pkg::ADDR_STATUS, data, resp);
		while (data[idx] !== val);
	endtask

	task automatic set_ctrl(input int new_div, input logic lb);
		logic [31:0] word;
		word = 32'(new_div);
		word[uart_pkg::CTRL_LOOPBACK] = lb;
		write_check("ctrl write", uart_pkg::ADDR_CTRL, word, uart_pkg::RESP_OKAY);
		read_check("ctrl read", uart_pkg::ADDR_CTRL, word);
		div = new_div;
	endtask

	// ************************************************************************
	// Serial side
	// ************************************************************************
	task automatic send_frame(input logic [7:0] data, input logic stop);
		@(negedge clk);
		rx = 1'b0;
		repeat (div) @(negedge clk);
		for (int i = 7; i >= 0; i--)
		begin
			rx = data[i];    // MSB first
			repeat (div) @(negedge clk);
		end
		rx = stop;
		repeat (div) @(negedge clk);
		rx = 1'b1;
	endtask

	task automatic watch_tx(output logic [7:0] data);
		do
			@(negedge clk);
		while (tx !== 1'b0);
		repeat (div / 2) @(negedge clk);    // Centre of start bit
		check("tx start bit", 32'd0, 32'(tx));
		for (int i = 7; i >= 0; i--)
		begin
			repeat (div) @(negedge clk);
			data[i] = tx;
		end
		repeat (div) @(negedge clk);
		check("tx stop bit", 32'd1, 32'(tx));
	endtask

	task automatic send_tx(input logic [7:0] data, input logic busy_write);
		logic [7:0]  seen;
		logic [31:0] st;
		logic [1:0]  resp;
		fork
			watch_tx(seen);
			begin
				write_check("txdata write", uart_pkg::ADDR_TXDATA, 32'(data), uart_pkg::RESP_OKAY);
				axi_read(uart_pkg::ADDR_STATUS, st, resp);
				check("status busy", 32'd1, 32'(st[uart_pkg::ST_TX_BUSY]));
				if (busy_write)
					write_check("txdata while busy", uart_pkg::ADDR_TXDATA, ~32'(data),
						uart_pkg::RESP_SLVERR);
			end
		join
		check("tx byte", 32'(data), 32'(seen));
		if (busy_write)
			repeat (12 * div)
			begin
				@(negedge clk);
				check("tx idle after dropped write", 32'd1, 32'(tx));    // No second frame
			end
		wait_status(uart_pkg::ST_TX_BUSY, 1'b0);
		read_check("status tx done", uart_pkg::ADDR_STATUS, exp_status(1'b0));
	endtask

	// Byte arrives either on the RX pin or through the loopback path
	task automatic recv_byte(input logic [7:0] data, input logic via_loopback);
		if (via_loopback)
			write_check("loopback txdata", uart_pkg::ADDR_TXDATA, 32'(data), uart_pkg::RESP_OKAY);
		else
			send_frame(data, 1'b1);
		wait_status(uart_pkg::ST_RX_VALID, 1'b1);
		m_rx_valid = 1'b1;
		m_rx_data  = data;
		read_check("status rx valid", uart_pkg::ADDR_STATUS, exp_status(1'b0));
		read_check("rxdata", uart_pkg::ADDR_RXDATA, 32'(data));
		m_rx_valid = 1'b0;
		read_check("status after rxdata read", uart_pkg::ADDR_STATUS, exp_status(1'b0));
	endtask

	initial
	begin
		logic [7:0]  b;
		logic [31:0] d;
		logic [1:0]  r;
		int          nd;
		rng         = 32'd91051;
		awvalid     = 1'b0;
		wvalid      = 1'b0;
		arvalid     = 1'b0;
		bready      = 1'b1;
		rready      = 1'b1;
		awaddr      = '0;
		araddr      = '0;
		wdata       = '0;
		rx          = 1'b1;
		lb_watch    = 1'b0;
		m_rx_data   = '0;
		m_rx_valid  = 1'b0;
		m_frame_err = 1'b0;
		m_overrun   = 1'b0;
		@(negedge clk);
		while (rst)
			@(negedge clk);
		read_check("status reset", uart_pkg::ADDR_STATUS, exp_status(1'b0));
		read_check("ctrl reset", uart_pkg::ADDR_CTRL, 32'(uart_pkg::DIV_RESET));
		set_ctrl(rand_range(MIN_DIV, MAX_DIV), 1'b0);

		repeat (N_RAND) send_tx(8'(rand_range(0, 255)), 1'b0);
		repeat (N_RAND)
		begin
			recv_byte(8'(rand_range(0, 255)), 1'b0);
			repeat (rand_range(0, 15)) @(negedge clk);
		end

		// Framing error, sticky until cleared
		send_frame(8'(rand_range(1, 255)), 1'b0);
		wait_status(uart_pkg::ST_FRAME_ERR, 1'b1);
		m_frame_err = 1'b1;
		read_check("status frame err", uart_pkg::ADDR_STATUS, exp_status(1'b0));
		read_check("rxdata kept", uart_pkg::ADDR_RXDATA, 32'(m_rx_data));
		read_check("frame err sticky", uart_pkg::ADDR_STATUS, exp_status(1'b0));
		write_check("clear frame err", uart_pkg::ADDR_STATUS, 32'd1 << uart_pkg::ST_FRAME_ERR,
			uart_pkg::RESP_OKAY);
		m_frame_err = 1'b0;
		read_check("frame err cleared", uart_pkg::ADDR_STATUS, exp_status(1'b0));

		set_ctrl(div, 1'b1);
		lb_watch = 1'b1;
		repeat (N_RAND) recv_byte(8'(rand_range(0, 255)), 1'b1);
		lb_watch = 1'b0;
		set_ctrl(div, 1'b0);

		// Overrun keeps the first byte
		b = 8'(rand_range(0, 255));
		send_frame(b, 1'b1);
		send_frame(8'(rand_range(0, 255)), 1'b1);
		wait_status(uart_pkg::ST_OVERRUN, 1'b1);
		m_rx_valid = 1'b1;
		m_rx_data  = b;
		m_overrun  = 1'b1;
		read_check("status overrun", uart_pkg::ADDR_STATUS, exp_status(1'b0));
		read_check("rxdata first byte", uart_pkg::ADDR_RXDATA, 32'(b));
		m_rx_valid = 1'b0;
		write_check("clear overrun", uart_pkg::ADDR_STATUS, 32'd1 << uart_pkg::ST_OVERRUN,
			uart_pkg::RESP_OKAY);
		m_overrun = 1'b0;
		read_check("overrun cleared", uart_pkg::ADDR_STATUS, exp_status(1'b0));

		nd = rand_range(MIN_DIV, MAX_DIV - 1);
		if (nd >= div)
			nd++;    // Always a different rate
		set_ctrl(nd, 1'b0);
		recv_byte(8'(rand_range(0, 255)), 1'b0);
		send_tx(8'(rand_range(0, 255)), 1'b0);

		write_check("unmapped write", 4'h2, 32'hFFFF_FFFF, uart_pkg::RESP_SLVERR);
		axi_read(4'h6, d, r);
		check("unmapped read resp", 32'(uart_pkg::RESP_SLVERR), 32'(r));
		check("unmapped read data", 32'd0, d);
		send_tx(8'(rand_range(0, 255)), 1'b1);

		if (fail_count == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== rtl/baud_tick_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module baud_tick_gen (
	input  wire                       i_CLK,
	input  wire                       i_RESET,
	input  wire [uart_pkg::DIV_W-1:0] i_div,
	input  wire                       i_reload,
	output logic                      o_tick
);

	logic [uart_pkg::DIV_W-1:0] count;
	logic [uart_pkg::DIV_W-1:0] div_eff;
	logic [uart_pkg::DIV_W-1:0] load_val;

	assign div_eff  = (i_div < uart_pkg::DIV_MIN) ? uart_pkg::DIV_MIN : i_div;
	assign load_val = div_eff - 1'b1;

	// Period is div_eff clocks, counter runs load_val down to zero
	always_ff @(posedge i_CLK)
	begin
		if (i_RESET || i_reload)
		begin
			count  <= load_val;
			o_tick <= 1'b0;
		end
		else if (count == '0)
		begin
			count  <= load_val;
			o_tick <= 1'b1;
		end
		else
		begin
			count  <= count - 1'b1;
			o_tick <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/uart_axil_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_axil_regs (
	input  wire                            i_CLK,
	input  wire                            i_RESET,
	input  wire                            i_awvalid,
	output logic                           o_awready,
	input  wire [uart_pkg::AXI_ADDR_W-1:0] i_awaddr,
	input  wire                            i_wvalid,
	output logic                           o_wready,
	input  wire [uart_pkg::AXI_DATA_W-1:0] i_wdata,
	output logic                           o_bvalid,
	input  wire                            i_bready,
	output logic [1:0]                     o_bresp,
	input  wire                            i_arvalid,
	output logic                           o_arready,
	input  wire [uart_pkg::AXI_ADDR_W-1:0] i_araddr,
	output logic                           o_rvalid,
	input  wire                            i_rready,
	output logic [uart_pkg::AXI_DATA_W-1:0] o_rdata,
	output logic [1:0]                     o_rresp,
	input  wire uart_pkg::rx_result_t      i_rx_result,
	input  wire                            i_tx_busy,
	output uart_pkg::tx_req_t              o_tx_req,
	output logic [uart_pkg::DIV_W-1:0]     o_div,
	output logic                           o_div_reload,
	output logic                           o_loopback
);

	uart_pkg::reg_addr_e             waddr;
	uart_pkg::reg_addr_e             raddr;
	logic                            wr_fire;
	logic                            rd_fire;
	logic                            tx_busy_eff;
	logic                            wr_tx;
	logic                            wr_status;
	logic                            wr_ctrl;
	logic                            wr_err;
	logic                            rd_err;
	logic                            rd_rxdata;
	logic [uart_pkg::AXI_DATA_W-1:0] rd_word;
	logic [uart_pkg::DATA_W-1:0]     rx_data;
	logic                            rx_valid;
	logic                            frame_err;
	logic                            overrun;

	assign wr_fire   = i_awvalid && i_wvalid && !o_bvalid;
	assign o_awready = wr_fire;
	assign o_wready  = wr_fire;
	assign o_arready = !o_rvalid;
	assign rd_fire   = i_arvalid && !o_rvalid;

	assign waddr = uart_pkg::reg_addr_e'(i_awaddr);
	assign raddr = uart_pkg::reg_addr_e'(i_araddr);

	// A request still in flight counts as busy
	assign tx_busy_eff = i_tx_busy || o_tx_req.valid;
	assign rd_rxdata   = rd_fire && raddr == uart_pkg::ADDR_RXDATA;

	// ************************************************************************
	// Address decode
	// ************************************************************************
	always_comb
	begin
		wr_tx     = 1'b0;
		wr_status = 1'b0;
		wr_ctrl   = 1'b0;
		wr_err    = 1'b0;
		case (waddr)
			uart_pkg::ADDR_TXDATA:
			begin
				if (tx_busy_eff)
					wr_err = 1'b1;
				else
					wr_tx = 1'b1;
			end
			uart_pkg::ADDR_RXDATA: ;    // Read only, write ignored
			uart_pkg::ADDR_STATUS: wr_status = 1'b1;
			uart_pkg::ADDR_CTRL:   wr_ctrl = 1'b1;
			default:               wr_err = 1'b1;
		endcase
	end

	always_comb
	begin
		rd_word = '0;
		rd_err  = 1'b0;
		case (raddr)
			uart_pkg::ADDR_TXDATA: ;
			uart_pkg::ADDR_RXDATA: rd_word[uart_pkg::DATA_W-1:0] = rx_data;
			uart_pkg::ADDR_STATUS:
			begin
				rd_word[uart_pkg::ST_TX_BUSY]   = tx_busy_eff;
				rd_word[uart_pkg::ST_RX_VALID]  = rx_valid;
				rd_word[uart_pkg::ST_FRAME_ERR] = frame_err;
				rd_word[uart_pkg::ST_OVERRUN]   = overrun;
			end
			uart_pkg::ADDR_CTRL:
			begin
				rd_word[uart_pkg::CTRL_DIV_LSB +: uart_pkg::DIV_W] = o_div;
				rd_word[uart_pkg::CTRL_LOOPBACK]                   = o_loopback;
			end
			default: rd_err = 1'b1;
		endcase
	end

	// ************************************************************************
	// Control state
	// ************************************************************************
	always_ff @(posedge i_CLK)
	begin
		if (i_RESET)
		begin
			o_bvalid       <= 1'b0;
			o_rvalid       <= 1'b0;
			o_tx_req.valid <= 1'b0;
			o_div          <= uart_pkg::DIV_RESET;
			o_div_reload   <= 1'b0;
			o_loopback     <= 1'b0;
			rx_valid       <= 1'b0;
			frame_err      <= 1'b0;
			overrun        <= 1'b0;
		end
		else
		begin
			o_tx_req.valid <= wr_fire && wr_tx;
			o_div_reload   <= wr_fire && wr_ctrl;

			if (wr_fire)
				o_bvalid <= 1'b1;
			else if (i_bready)
				o_bvalid <= 1'b0;
			if (rd_fire)
				o_rvalid <= 1'b1;
			else if (i_rready)
				o_rvalid <= 1'b0;

			if (wr_fire && wr_ctrl)
			begin
				o_div      <= i_wdata[uart_pkg::CTRL_DIV_LSB +: uart_pkg::DIV_W];
				o_loopback <= i_wdata[uart_pkg::CTRL_LOOPBACK];
			end

			// W1C first so a new event in the same cycle wins
			if (wr_fire && wr_status && i_wdata[uart_pkg::ST_FRAME_ERR])
				frame_err <= 1'b0;
			if (wr_fire && wr_status && i_wdata[uart_pkg::ST_OVERRUN])
				overrun <= 1'b0;
			if (rd_rxdata)
				rx_valid <= 1'b0;

			if (i_rx_result.valid)
			begin
				if (i_rx_result.framing_error)
					frame_err <= 1'b1;
				else if (rx_valid && !rd_rxdata)
					overrun <= 1'b1;    // Older byte kept
				else
					rx_valid <= 1'b1;
			end
		end
	end

	// Payload registers
	always_ff @(posedge i_CLK)
	begin
		if (wr_fire)
		begin
			o_bresp       <= wr_err ? uart_pkg::RESP_SLVERR : uart_pkg::RESP_OKAY;
			o_tx_req.data <= i_wdata[uart_pkg::DATA_W-1:0];
		end
		if (rd_fire)
		begin
			o_rdata <= rd_word;
			o_rresp <= rd_err ? uart_pkg::RESP_SLVERR : uart_pkg::RESP_OKAY;
		end
		if (i_rx_result.valid && !i_rx_result.framing_error && (!rx_valid || rd_rxdata))
			rx_data <= i_rx_result.data;
	end

endmodule

`default_nettype wire

// ==== rtl/uart_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_top (
	input  wire                             i_CLK,
	input  wire                             i_RESET,
	input  wire                             i_awvalid,
	output logic                            o_awready,
	input  wire [uart_pkg::AXI_ADDR_W-1:0]  i_awaddr,
	input  wire                             i_wvalid,
	output logic                            o_wready,
	input  wire [uart_pkg::AXI_DATA_W-1:0]  i_wdata,
	output logic                            o_bvalid,
	input  wire                             i_bready,
	output logic [1:0]                      o_bresp,
	input  wire                             i_arvalid,
	output logic                            o_arready,
	input  wire [uart_pkg::AXI_ADDR_W-1:0]  i_araddr,
	output logic                            o_rvalid,
	input  wire                             i_rready,
	output logic [uart_pkg::AXI_DATA_W-1:0] o_rdata,
	output logic [1:0]                      o_rresp,
	input  wire                             i_RX,
	output logic                            o_TX
);

	uart_pkg::rx_result_t       rx_result;
	uart_pkg::tx_req_t          tx_req;
	logic [uart_pkg::DIV_W-1:0] div;
	logic                       div_reload;
	logic                       loopback;
	logic                       tick;
	logic                       tx_busy;
	logic                       tx_line;
	logic                       rx_line;

	// Internal loopback, pin held idle meanwhile
	assign rx_line = loopback ? tx_line : i_RX;
	assign o_TX    = loopback ? 1'b1 : tx_line;

	baud_tick_gen u_tick (
		.i_CLK    (i_CLK),
		.i_RESET  (i_RESET),
		.i_div    (div),
		.i_reload (div_reload),
		.o_tick   (tick)
	);

	uart_receiver u_rx (
		.i_CLK    (i_CLK),
		.i_RESET  (i_RESET),
		.i_tick   (tick),
		.i_rx     (rx_line),
		.o_result (rx_result)
	);

	uart_transmitter u_tx (
		.i_CLK   (i_CLK),
		.i_RESET (i_RESET),
		.i_tick  (tick),
		.i_req   (tx_req),
		.o_tx    (tx_line),
		.o_busy  (tx_busy)
	);

	uart_axil_regs u_regs (
		.i_CLK        (i_CLK),
		.i_RESET      (i_RESET),
		.i_awvalid    (i_awvalid),
		.o_awready    (o_awready),
		.i_awaddr     (i_awaddr),
		.i_wvalid     (i_wvalid),
		.o_wready     (o_wready),
		.i_wdata      (i_wdata),
		.o_bvalid     (o_bvalid),
		.i_bready     (i_bready),
		.o_bresp      (o_bresp),
		.i_arvalid    (i_arvalid),
		.o_arready    (o_arready),
		.i_araddr     (i_araddr),
		.o_rvalid     (o_rvalid),
		.i_rready     (i_rready),
		.o_rdata      (o_rdata),
		.o_rresp      (o_rresp),
		.i_rx_result  (rx_result),
		.i_tx_busy    (tx_busy),
		.o_tx_req     (tx_req),
		.o_div        (div),
		.o_div_reload (div_reload),
		.o_loopback   (loopback)
	);

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Build the UART testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --top-module uart_tb -f all.f -o uart_sim \
	&& ./obj_dir/uart_sim > sim.log 2>&1
cat sim.log 2>/dev/null

grep -q "^RESULT: PASS$" sim.log 2>/dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// ==== uart_receiver/uart_receiver.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_receiver (
	input  wire                  i_CLK,
	input  wire                  i_RESET,
	input  wire                  i_tick,
	input  wire                  i_rx,
	output uart_pkg::rx_result_t o_result
);

	uart_pkg::rx_state_e              state;
	logic [uart_pkg::BIT_CNT_W-1:0]   bit_cnt;
	logic [uart_pkg::DATA_W-1:0]      shift;
	logic                             rx_meta;
	logic                             rx_sync;

	// Line idles high, so the synchronizer resets to 1
	always_ff @(posedge i_CLK)
	begin
		if (i_RESET)
		begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end
		else
		begin
			rx_meta <= i_rx;
			rx_sync <= rx_meta;
		end
	end

	// ************************************************************************
	// Frame FSM, one sample per tick
	// ************************************************************************
	always_ff @(posedge i_CLK)
	begin
		if (i_RESET)
		begin
			state    <= uart_pkg::RX_IDLE;
			bit_cnt  <= '0;
			o_result <= '0;
		end
		else
		begin
			o_result.valid <= 1'b0;    // Single-cycle pulse
			if (i_tick)
			begin
				case (state)
					uart_pkg::RX_IDLE:
					begin
						bit_cnt <= '0;
						if (!rx_sync)
							state <= uart_pkg::RX_DATA;    // Start bit
					end
					uart_pkg::RX_DATA:
					begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == uart_pkg::BIT_CNT_W'(uart_pkg::DATA_W - 1))
							state <= uart_pkg::RX_STOP;
					end
					uart_pkg::RX_STOP:
					begin
						state                  <= uart_pkg::RX_IDLE;
						o_result.valid         <= 1'b1;
						o_result.framing_error <= !rx_sync;
						o_result.data          <= rx_sync ? shift : '0;
					end
					default:
						state <= uart_pkg::RX_IDLE;
				endcase
			end
		end
	end

	// First bit in ends up in the MSB
	always_ff @(posedge i_CLK)
	begin
		if (i_tick && state == uart_pkg::RX_DATA)
			shift <= {shift[uart_pkg::DATA_W-2:0], rx_sync};
	end

endmodule

`default_nettype wire

// ==== uart_transmitter/uart_transmitter.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_transmitter (
	input  wire                    i_CLK,
	input  wire                    i_RESET,
	input  wire                    i_tick,
	input  wire uart_pkg::tx_req_t i_req,
	output logic                   o_tx,
	output logic                   o_busy
);

	uart_pkg::tx_state_e            state;
	logic [uart_pkg::BIT_CNT_W-1:0] bit_cnt;
	logic [uart_pkg::DATA_W-1:0]    shift;

	always_ff @(posedge i_CLK)
	begin
		if (i_RESET)
		begin
			state   <= uart_pkg::TX_IDLE;
			bit_cnt <= '0;
			o_tx    <= 1'b1;
			o_busy  <= 1'b0;
		end
		else
		begin
			case (state)
				uart_pkg::TX_IDLE:
				begin
					if (i_req.valid)
					begin
						state  <= uart_pkg::TX_START;
						o_busy <= 1'b1;
					end
				end
				uart_pkg::TX_START:    // Waiting for the tick that opens the frame
				begin
					if (i_tick)
					begin
						o_tx    <= 1'b0;
						bit_cnt <= '0;
						state   <= uart_pkg::TX_DATA;
					end
				end
				uart_pkg::TX_DATA:
				begin
					if (i_tick)
					begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == uart_pkg::BIT_CNT_W'(uart_pkg::DATA_W))
						begin
							o_tx  <= 1'b1;    // Stop bit
							state <= uart_pkg::TX_STOP;
						end
						else
							o_tx <= shift[uart_pkg::DATA_W-1];
					end
				end
				uart_pkg::TX_STOP:
				begin
					if (i_tick)
					begin
						o_busy <= 1'b0;
						state  <= uart_pkg::TX_IDLE;
					end
				end
				default:
					state <= uart_pkg::TX_IDLE;
			endcase
		end
	end

	// MSB first
	always_ff @(posedge i_CLK)
	begin
		if (state == uart_pkg::TX_IDLE && i_req.valid)
			shift <= i_req.data;
		else if (state == uart_pkg::TX_DATA && i_tick)
			shift <= {shift[uart_pkg::DATA_W-2:0], 1'b0};
	end

endmodule

`default_nettype wire
